/* logic/adc_serial_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial controller for the AD7685 style converter
// cnv phase, 16 sck pulses, msb first shift-in
// and the result valid flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module adc_serial_if #(
	parameter int CONV_CYCLES = lcms_adc_pkg::DEF_CONV_CYCLES	// cnv high time in cycles
) (
	input  wire                   adc_sm_clk,
	input  wire                   adc_sm_rst,
	input  wire                   cnv_start_i,	// one-cycle conversion request
	input  wire                   adc_sdo_i,	// serial data from the converter
	output logic                  adc_cnv_o,	// conversion in progress
	output logic                  adc_sck_o,	// read-out clock
	output lcms_adc_pkg::sample_t result_o,	// last word read
	output logic                  result_valid_o	// one cycle after the last bit
);
	import lcms_adc_pkg::*;

	localparam int CNT_W       = 16;
	localparam int READ_CYCLES = 2 * ADC_BITS;	// one high and one low cycle per bit

	typedef enum logic [1:0] {
		SER_IDLE,	// waiting for a start, starts while busy are lost
		SER_CONV,	// cnv high
		SER_READ	// clocking out the word
	} ser_state_e;

	ser_state_e       state;
	logic [CNT_W-1:0] cnt;	// cnv cycles, then read-out phase

	// the converter drives a new bit on each sck falling edge,
	// so the bit is taken at the clock edge that raises sck
	always_ff @(posedge adc_sm_clk) begin
		if ((state == SER_READ) && !cnt[0]) begin
			result_o <= {result_o[ADC_BITS-2:0], adc_sdo_i};	// msb first
		end
	end

	always_ff @(posedge adc_sm_clk) begin
		if (adc_sm_rst) begin
			state          <= SER_IDLE;
			cnt            <= '0;
			adc_cnv_o      <= 1'b0;
			adc_sck_o      <= 1'b0;
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= 1'b0;
			case (state)
				SER_IDLE: begin
					if (cnv_start_i) begin
						adc_cnv_o <= 1'b1;
						cnt       <= '0;
						state     <= SER_CONV;
					end
				end
				SER_CONV: begin
					if (cnt == CNT_W'(CONV_CYCLES - 1)) begin
						adc_cnv_o <= 1'b0;	// msb appears on sdo here
						cnt       <= '0;
						state     <= SER_READ;	// one low cycle before the first sck
					end else begin
						cnt <= cnt + CNT_W'(1);
					end
				end
				SER_READ: begin
					adc_sck_o <= ~cnt[0];	// even phase raises sck, odd drops it
					if (cnt == CNT_W'(READ_CYCLES - 1)) begin
						result_valid_o <= 1'b1;	// word complete
						cnt            <= '0;
						state          <= SER_IDLE;
					end else begin
						cnt <= cnt + CNT_W'(1);
					end
				end
				default: begin
					state <= SER_IDLE;
				end
			endcase
		end
	end

	// start to result_valid is CONV_CYCLES + 33 cycles:
	// registered cnv, CONV_CYCLES high, one gap, 32 sck phases

endmodule

`default_nettype wire

/* logic/cds_strobe_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// software cds strobes
// two conversion strobes at programmable delays
// after each integrator reset, plus second-sample flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cds_strobe_gen (
	input  wire         adc_sm_clk,
	input  wire         adc_sm_rst,
	input  wire         int_reset_rise_i,	// rising edge of the integrator reset
	input  wire  [15:0] cds_delay1_i,	// cycles from edge to first strobe
	input  wire  [15:0] cds_delay2_i,	// cycles from edge to second strobe
	output logic        cds_strobe_o,	// conversion request
	output logic        cds_first_o	// high with the second strobe
);

	logic [15:0] delay_cnt;	// cycles since the last edge
	logic        counting;	// window between edge and second strobe
	logic        hit1;
	logic        hit2;

	// delay_cnt reads k exactly k cycles after the edge
	assign hit1 = counting && (delay_cnt == cds_delay1_i);
	assign hit2 = counting && (delay_cnt == cds_delay2_i);

	assign cds_strobe_o = hit1 | hit2;

	// naming follows the chip docs: the flag marks the sample
	// that completes the pair, i.e. the second one
	assign cds_first_o = hit2;

	always_ff @(posedge adc_sm_clk) begin
		if (adc_sm_rst) begin
			counting  <= 1'b0;
			delay_cnt <= '0;
		end else if (int_reset_rise_i) begin
			// a new edge always restarts the pair
			counting  <= 1'b1;
			delay_cnt <= 16'd1;
		end else if (counting) begin
			if (hit2) begin
				counting <= 1'b0;	// pair done, wait for the next reset
			end else begin
				delay_cnt <= delay_cnt + 16'd1;
			end
		end
	end

	// delays are expected as 0 < delay1 < delay2, with room
	// between them for a full conversion and read-out

endmodule

`default_nettype wire

/* logic/lcms_adc_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the adc measurement path
// sample word, measurement mode, capture states
// default timing of the adc_sm_clk domain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lcms_adc_pkg;

	// converter word, AD7685 style part
	parameter int ADC_BITS = 16;

	// one raw conversion or one cds difference
	typedef logic [ADC_BITS-1:0] sample_t;

	// measurement mode as set by the host
	typedef enum logic {
		MODE_VOLTAGE = 1'b0,	// synchronous voltage, one sample per period
		MODE_CDS     = 1'b1	// software cds, two samples per integrator reset
	} meas_mode_e;

	// capture fsm
	typedef enum logic [1:0] {
		CAP_VOLTAGE,	// forward single results
		CAP_CDS_SAMPLE,	// collect first and second sample
		CAP_CDS_DIFF,	// second minus first
		CAP_CDS_TX	// hold difference until the host takes it
	} capture_state_e;

	// adc_sm_clk runs at 20 MHz on the board
	parameter int unsigned DEF_CLK_PER_US = 32'd20;

	// 8 us of settling after the sampling pulse
	parameter int DEF_SETTLE_CYCLES = 160;

	// cnv high time, 2 us at 20 MHz
	parameter int DEF_CONV_CYCLES = 40;

endpackage

`default_nettype wire

/* logic/lcms_adc_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adc measurement path top level
// timer, cds strobes, serial controller, capture
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lcms_adc_top #(
	parameter int unsigned CLK_PER_US    = lcms_adc_pkg::DEF_CLK_PER_US,
	parameter int          SETTLE_CYCLES = lcms_adc_pkg::DEF_SETTLE_CYCLES,
	parameter int          CONV_CYCLES   = lcms_adc_pkg::DEF_CONV_CYCLES
) (
	input  wire                           adc_sm_clk,
	input  wire                           adc_sm_rst,
	input  wire                           start_meas_i,	// run enable
	input  wire lcms_adc_pkg::meas_mode_e mode_i,	// voltage or software cds
	input  wire                           int_reset_i,	// integrator reset from the chip
	input  wire  [15:0]                   v_sampling_period_i,	// us
	input  wire  [15:0]                   cds_delay1_i,	// cycles after integrator reset
	input  wire  [15:0]                   cds_delay2_i,
	input  wire                           adc_sdo_i,
	input  wire                           sample_ready_i,
	output logic                          adc_cnv_o,
	output logic                          adc_sck_o,
	output lcms_adc_pkg::sample_t         sample_o,
	output logic                          sample_valid_o
);
	import lcms_adc_pkg::*;

	logic    int_reset_rise;
	logic    fs_pulse;
	logic    cds_strobe;
	logic    cds_first;
	logic    cnv_start;
	sample_t adc_result;
	logic    adc_result_valid;

	sample_timer #(.CLK_PER_US(CLK_PER_US)) timer0 (
		.adc_sm_clk(adc_sm_clk), .adc_sm_rst(adc_sm_rst),
		.start_meas_i(start_meas_i), .int_reset_i(int_reset_i),
		.v_sampling_period_i(v_sampling_period_i),
		.int_reset_rise_o(int_reset_rise), .fs_pulse_o(fs_pulse)
	);

	cds_strobe_gen cds0 (	// software cds pair after each integrator reset
		.adc_sm_clk(adc_sm_clk), .adc_sm_rst(adc_sm_rst),
		.int_reset_rise_i(int_reset_rise),
		.cds_delay1_i(cds_delay1_i), .cds_delay2_i(cds_delay2_i),
		.cds_strobe_o(cds_strobe), .cds_first_o(cds_first)
	);

	adc_serial_if #(.CONV_CYCLES(CONV_CYCLES)) adc0 (
		.adc_sm_clk(adc_sm_clk), .adc_sm_rst(adc_sm_rst),
		.cnv_start_i(cnv_start), .adc_sdo_i(adc_sdo_i),
		.adc_cnv_o(adc_cnv_o), .adc_sck_o(adc_sck_o),
		.result_o(adc_result), .result_valid_o(adc_result_valid)
	);

	sample_capture #(.SETTLE_CYCLES(SETTLE_CYCLES)) cap0 (
		.adc_sm_clk(adc_sm_clk), .adc_sm_rst(adc_sm_rst),
		.start_meas_i(start_meas_i), .mode_i(mode_i),
		.fs_pulse_i(fs_pulse), .cds_strobe_i(cds_strobe), .cds_first_i(cds_first),
		.result_i(adc_result), .result_valid_i(adc_result_valid),
		.sample_ready_i(sample_ready_i), .cnv_start_o(cnv_start),
		.sample_o(sample_o), .sample_valid_o(sample_valid_o)
	);

endmodule

`default_nettype wire

/* logic/sample_capture.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// conversion strobe selection and settling delay
// capture fsm with cds pair subtraction
// output sample stream toward the host buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sample_capture #(
	parameter int SETTLE_CYCLES = lcms_adc_pkg::DEF_SETTLE_CYCLES	// settling after fs pulse
) (
	input  wire                       adc_sm_clk,
	input  wire                       adc_sm_rst,
	input  wire                       start_meas_i,	// measurement enable
	input  wire lcms_adc_pkg::meas_mode_e mode_i,	// taken only while stopped
	input  wire                       fs_pulse_i,	// voltage mode sampling pulse
	input  wire                       cds_strobe_i,	// cds conversion strobe
	input  wire                       cds_first_i,	// set with the second cds strobe
	input  wire lcms_adc_pkg::sample_t    result_i,	// converter word
	input  wire                       result_valid_i,
	input  wire                       sample_ready_i,	// host buffer has room
	output logic                      cnv_start_o,	// to the serial controller
	output lcms_adc_pkg::sample_t     sample_o,
	output logic                      sample_valid_o
);
	import lcms_adc_pkg::*;

	logic [SETTLE_CYCLES-1:0] settle_sr;	// fs pulse walks through here
	logic                     cds_active;	// fsm is on the cds side
	logic                     strobe_sel;	// strobe of the active mode
	logic                     cnv_req;
	logic                     second_pending;	// conversion in flight is the second of a pair
	logic                     volt_push;	// voltage result waiting one cycle
	capture_state_e           state;
	sample_t                  first_q;	// first cds sample
	sample_t                  second_q;	// second cds sample
	sample_t                  out_q;	// word on the stream

	// the fsm state carries the mode, so a mode change mid-run has no effect
	assign cds_active = (state != CAP_VOLTAGE);
	assign strobe_sel = cds_active ? cds_strobe_i : settle_sr[SETTLE_CYCLES-1];
	assign cnv_req    = strobe_sel & start_meas_i;	// no conversions while stopped

	// valid only with ready, a voltage word without ready is lost
	// and a cds difference waits in CAP_CDS_TX
	assign sample_valid_o = (volt_push | (state == CAP_CDS_TX)) & sample_ready_i;
	assign sample_o       = out_q;

	always_ff @(posedge adc_sm_clk) begin
		if (adc_sm_rst) begin
			settle_sr      <= '0;
			cnv_start_o    <= 1'b0;
			second_pending <= 1'b0;
			volt_push      <= 1'b0;
			state          <= CAP_VOLTAGE;
		end else begin
			settle_sr   <= {settle_sr[SETTLE_CYCLES-2:0], fs_pulse_i};	// SETTLE_CYCLES late
			cnv_start_o <= cnv_req;	// one cycle after the strobe
			if (cnv_req) begin
				second_pending <= cds_first_i;	// flag travels with the conversion
			end
			volt_push <= 1'b0;

			case (state)
				CAP_VOLTAGE: begin
					if (!start_meas_i && (mode_i == MODE_CDS)) begin
						state <= CAP_CDS_SAMPLE;
					end else if (result_valid_i) begin
						volt_push <= 1'b1;	// pushed next cycle if ready
					end
				end
				CAP_CDS_SAMPLE: begin
					if (!start_meas_i && (mode_i == MODE_VOLTAGE)) begin
						state <= CAP_VOLTAGE;
					end else if (result_valid_i && second_pending) begin
						state <= CAP_CDS_DIFF;	// pair complete
					end
				end
				CAP_CDS_DIFF: begin
					state <= CAP_CDS_TX;
				end
				CAP_CDS_TX: begin
					if (sample_ready_i) begin
						state <= CAP_CDS_SAMPLE;	// delivered once
					end
				end
				default: begin
					state <= CAP_VOLTAGE;
				end
			endcase
		end
	end

	// sample payload, follows the fsm above
	always_ff @(posedge adc_sm_clk) begin
		case (state)
			CAP_VOLTAGE: begin
				if (result_valid_i) begin
					out_q <= result_i;
				end
			end
			CAP_CDS_SAMPLE: begin
				if (result_valid_i) begin
					if (second_pending) begin
						second_q <= result_i;
					end else begin
						first_q <= result_i;
					end
				end
			end
			CAP_CDS_DIFF: begin
				out_q <= second_q - first_q;	// wraps modulo 2^16
			end
			default: begin
				out_q <= out_q;	// held steady in CAP_CDS_TX
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/sample_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sampling period timer
// integrator reset edge detect, armed period counter
// and the one-cycle sampling pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sample_timer #(
	parameter int unsigned CLK_PER_US = lcms_adc_pkg::DEF_CLK_PER_US	// clock cycles per us
) (
	input  wire         adc_sm_clk,
	input  wire         adc_sm_rst,
	input  wire         start_meas_i,	// measurement enable level
	input  wire         int_reset_i,	// integrator reset from the chip
	input  wire  [15:0] v_sampling_period_i,	// sampling period in us
	output logic        int_reset_rise_o,	// one cycle on each rising edge
	output logic        fs_pulse_o	// sampling pulse
);

	logic        int_reset_q;	// integrator reset, one cycle old
	logic        armed;	// timer running
	logic [31:0] period_cycles;	// period in clock cycles
	logic [31:0] period_cnt;	// cycles since the last pulse

	// the only edge detector of the path, cds_strobe_gen reuses it
	assign int_reset_rise_o = int_reset_i & ~int_reset_q;

	assign period_cycles = 32'(v_sampling_period_i) * CLK_PER_US;	// us to cycles

	always_ff @(posedge adc_sm_clk) begin
		if (adc_sm_rst) begin
			int_reset_q <= 1'b0;
			armed       <= 1'b0;
			period_cnt  <= '0;
			fs_pulse_o  <= 1'b0;
		end else begin
			int_reset_q <= int_reset_i;
			fs_pulse_o  <= 1'b0;	// pulse lasts one cycle

			if (!start_meas_i) begin
				// stop disarms, a new run waits for the next edge
				armed      <= 1'b0;
				period_cnt <= '0;
			end else if (!armed) begin
				if (int_reset_rise_o) begin
					armed      <= 1'b1;
					fs_pulse_o <= 1'b1;	// first sample right after the edge
					period_cnt <= '0;
				end
			end else if (period_cnt == period_cycles - 32'd1) begin
				fs_pulse_o <= 1'b1;	// period complete
				period_cnt <= '0;
			end else begin
				period_cnt <= period_cnt + 32'd1;
			end
			// later edges while armed do not move the phase
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the adc path testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps -f verilog.f \
	--top-module tb_lcms_adc -o tb_lcms_adc > sim.log 2>&1 \
	&& ./obj_dir/tb_lcms_adc >> sim.log 2>&1
cat sim.log
grep -q -x "test passed" sim.log && exit 0 || exit 1

/* test/adc_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioural AD7685 style converter
// serves the testbench word msb first on sdo
// and reports each word that was fully read out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module adc_model (
	input  wire                        adc_cnv_i,	// conversion in progress
	input  wire                        adc_sck_i,	// read-out clock
	input  wire lcms_adc_pkg::sample_t word_i,	// value for the next conversion
	output logic                       adc_sdo_o,
	output lcms_adc_pkg::sample_t      word_o,	// last word read out
	output logic [31:0]                word_cnt_o	// words read so far
);
	import lcms_adc_pkg::*;

	sample_t shreg;	// bits still to go out
	sample_t held;	// copy of the converted value

	initial begin
		adc_sdo_o  = 1'b0;
		word_o     = '0;
		word_cnt_o = '0;
		shreg      = '0;
		held       = '0;
		forever begin
			@(posedge adc_cnv_i);
			@(negedge adc_cnv_i);	// end of conversion
			held      = word_i;
			shreg     = word_i;
			adc_sdo_o = shreg[ADC_BITS-1];	// msb is out before the first sck
			for (int i = 0; i < ADC_BITS; i++) begin
				@(negedge adc_sck_i);
				shreg     = shreg << 1;	// next bit on each falling sck
				adc_sdo_o = shreg[ADC_BITS-1];
			end
			word_o     = held;
			word_cnt_o = word_cnt_o + 32'd1;	// the checker watches this count
		end
	end

endmodule

`default_nettype wire

/* test/tb_lcms_adc.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the adc measurement path
// clock, reset, lfsr stimulus, converter model
// and assertion checks on converter and sample stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_lcms_adc;
	import lcms_adc_pkg::*;

	localparam int CONV_C = 6;	// cnv high time of the short build

	logic        adc_sm_clk;
	logic        adc_sm_rst;
	logic        start_meas_i;
	meas_mode_e  mode_i;
	logic        int_reset_i;
	logic [15:0] v_sampling_period_i;
	logic [15:0] cds_delay1_i;
	logic [15:0] cds_delay2_i;
	logic        adc_sdo_i;
	logic        sample_ready_i = 1'b0;
	logic        adc_cnv_o;
	logic        adc_sck_o;
	sample_t     sample_o;
	logic        sample_valid_o;

	logic [31:0] lfsr = 32'hbd14;
	sample_t     conv_word = '0;	// value the model converts next
	sample_t     next_word;
	logic        word_fresh = 1'b0;
	logic        hold_low = 1'b0;	// ready forced low
	logic        quiet_chk = 1'b0;	// no cnv and no valid allowed
	sample_t     word_val;
	logic [31:0] word_cnt;

	sample_t     exp_q[$];	// voltage words waiting for the stream
	sample_t     exp_val;
	sample_t     cds_first_val;
	sample_t     cds_exp;	// expected difference
	logic [31:0] word_seen = '0;
	logic        cnv_prev = 1'b0;
	logic        sck_prev = 1'b0;
	logic        conv_busy = 1'b0;
	logic        volt_due = 1'b0;	// voltage word goes out this cycle
	logic        cds_have_first = 1'b0;
	logic        cds_pending = 1'b0;
	int          cnv_len = 0;
	int          sck_pulses = 0;
	int          cds_age = 0;	// cycles since the second word
	int          volt_acc = 0;
	int          volt_drop = 0;
	int          cds_acc = 0;

	lcms_adc_top #(.CLK_PER_US(2), .SETTLE_CYCLES(12), .CONV_CYCLES(CONV_C)) dut0 (
		.adc_sm_clk(adc_sm_clk), .adc_sm_rst(adc_sm_rst),
		.start_meas_i(start_meas_i), .mode_i(mode_i), .int_reset_i(int_reset_i),
		.v_sampling_period_i(v_sampling_period_i),
		.cds_delay1_i(cds_delay1_i), .cds_delay2_i(cds_delay2_i),
		.adc_sdo_i(adc_sdo_i), .sample_ready_i(sample_ready_i),
		.adc_cnv_o(adc_cnv_o), .adc_sck_o(adc_sck_o),
		.sample_o(sample_o), .sample_valid_o(sample_valid_o)
	);

	adc_model model0 (
		.adc_cnv_i(adc_cnv_o), .adc_sck_i(adc_sck_o), .word_i(conv_word),
		.adc_sdo_o(adc_sdo_i), .word_o(word_val), .word_cnt_o(word_cnt)
	);

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic step(input int n);
		repeat (n) @(posedge adc_sm_clk);
	endtask

	task automatic pulse_int_reset();
		int_reset_i <= 1'b1;
		step(3);
		int_reset_i <= 1'b0;
	endtask

	// integrator resets with the measurement stopped
	task automatic idle_phase(input int n);
		quiet_chk <= 1'b1;
		repeat (n) begin
			pulse_int_reset();
			step(80);
		end
		quiet_chk <= 1'b0;
	endtask

	task automatic wait_pending(input logic want, input int limit);
		int n;
		n = 0;
		while ((cds_pending != want) && (n < limit)) begin
			@(posedge adc_sm_clk);
			n++;
		end
		if (cds_pending != want) abort_run("timeout waiting on the cds difference");
	endtask

	task automatic stop_run();
		int n;
		n = 0;
		start_meas_i <= 1'b0;
		step(4);	// a strobe right before the stop still converts
		while ((conv_busy || volt_due || cds_pending) && (n < 200)) begin
			@(posedge adc_sm_clk);
			n++;
		end
		if (conv_busy || volt_due || cds_pending)
			abort_run("timeout waiting for the converter to go idle");
	endtask

	initial begin
		adc_sm_clk = 1'b0;
		forever #2 adc_sm_clk = ~adc_sm_clk;
	end

	// new word once per cnv and one random ready bit per cycle
	always @(posedge adc_sm_clk) begin
		if (adc_cnv_o && !word_fresh) begin
			for (int i = 0; i < ADC_BITS; i++) begin
				next_word = {next_word[ADC_BITS-2:0], lfsr[0]};
				lfsr      = lfsr_step(lfsr);
			end
			conv_word <= next_word;
		end
		word_fresh = adc_cnv_o;
		sample_ready_i <= lfsr[0] & ~hold_low;
		lfsr = lfsr_step(lfsr);
	end

	// checks at mid-cycle where all signals have settled
	always @(negedge adc_sm_clk) begin
		if (!adc_sm_rst) begin
			if (adc_cnv_o && !cnv_prev) begin
				cnv_len    = 0;	// new conversion
				sck_pulses = 0;
				conv_busy  = 1'b1;
			end
			if (adc_cnv_o) cnv_len++;
			if (!adc_cnv_o && cnv_prev) begin
				assert (cnv_len == CONV_C)
					else abort_run($sformatf("MISMATCH cnv length: got %h expected %h",
						cnv_len, CONV_C));
			end
			if (adc_sck_o && !sck_prev) sck_pulses++;
			cnv_prev = adc_cnv_o;
			sck_prev = adc_sck_o;

			if (quiet_chk) begin
				assert (!adc_cnv_o && !sample_valid_o)
					else abort_run("conversion or sample seen while the measurement is stopped");
			end
			assert (!sample_valid_o || sample_ready_i)
				else abort_run("sample_valid_o high while sample_ready_i is low");

			if (volt_due) begin
				volt_due = 1'b0;
				exp_val  = exp_q.pop_front();
				if (sample_ready_i) begin
					assert (sample_valid_o) else abort_run("voltage sample not offered");
					assert (sample_o == exp_val)
						else abort_run($sformatf("MISMATCH sample_o: got %h expected %h",
							sample_o, exp_val));
					volt_acc++;
				end else begin
					volt_drop++;	// ready was low so this word is lost
				end
			end else if (cds_pending) begin
				if (cds_age >= 1) begin
					assert (sample_o == cds_exp)
						else abort_run($sformatf("MISMATCH sample_o: got %h expected %h",
							sample_o, cds_exp));
				end
				if (sample_valid_o) begin
					assert (cds_age >= 1) else abort_run("cds difference offered too early");
					cds_pending = 1'b0;
					cds_acc++;
				end
				cds_age++;
			end else begin
				assert (!sample_valid_o) else abort_run("sample_valid_o with no pending sample");
			end

			if (word_cnt != word_seen) begin
				word_seen = word_seen + 32'd1;
				conv_busy = 1'b0;
				assert (sck_pulses == 16)
					else abort_run($sformatf("MISMATCH sck pulses: got %h expected %h",
						sck_pulses, 16));
				if (mode_i == MODE_CDS) begin
					if (!cds_have_first) begin
						cds_first_val  = word_val;
						cds_have_first = 1'b1;
					end else begin
						cds_exp        = word_val - cds_first_val;	// wraps at 16 bits
						cds_have_first = 1'b0;
						cds_pending    = 1'b1;
						cds_age        = 0;
					end
				end else begin
					exp_q.push_back(word_val);
					volt_due = 1'b1;	// on the stream next cycle
				end
			end
		end
	end

	initial begin
		adc_sm_rst          = 1'b1;
		start_meas_i        = 1'b0;
		mode_i              = MODE_VOLTAGE;
		int_reset_i         = 1'b0;
		v_sampling_period_i = 16'd30;	// 60 cycles
		cds_delay1_i        = 16'd4;
		cds_delay2_i        = 16'd60;
		step(8);
		adc_sm_rst <= 1'b0;
		@(negedge adc_sm_clk);
		assert (!sample_valid_o && !adc_cnv_o && !adc_sck_o)
			else abort_run("outputs not low after reset");
		@(posedge adc_sm_clk);
		idle_phase(3);

		start_meas_i <= 1'b1;	// voltage mode with random ready
		pulse_int_reset();
		step(600);
		stop_run();
		idle_phase(2);

		mode_i <= MODE_CDS;
		step(4);
		start_meas_i <= 1'b1;
		repeat (4) begin
			pulse_int_reset();
			step(150);
		end
		hold_low <= 1'b1;	// difference waits for the host
		pulse_int_reset();
		wait_pending(1'b1, 200);
		step(20);
		hold_low <= 1'b0;
		wait_pending(1'b0, 60);
		step(60);
		repeat (2) begin
			pulse_int_reset();
			step(150);
		end
		stop_run();
		idle_phase(1);

		mode_i <= MODE_VOLTAGE;	// back to voltage with the first words dropped
		step(4);
		start_meas_i <= 1'b1;
		hold_low     <= 1'b1;
		pulse_int_reset();
		step(150);
		hold_low <= 1'b0;
		step(300);
		stop_run();

		assert ((exp_q.size() == 0) && !cds_pending && (sck_pulses == 16))
			else abort_run("results left unchecked at the end of the run");
		assert ((volt_acc > 0) && (volt_drop > 0))
			else abort_run("voltage mode did not both deliver and drop samples");
		assert (cds_acc == 7)
			else abort_run($sformatf("MISMATCH cds sample count: got %h expected %h",
				cds_acc, 7));
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
logic/lcms_adc_pkg.sv
logic/sample_timer.sv
logic/cds_strobe_gen.sv
logic/adc_serial_if.sv
logic/sample_capture.sv
logic/lcms_adc_top.sv
test/adc_model.sv
test/tb_lcms_adc.sv
